/* verification/golden_program.txt */
# P <instruction word, hex>
# R <register, decimal> <expected value, hex> <test name>
P 2001fffb
R 1 fffffffb addi_neg
P 2002000c
R 2 0000000c addi_pos
P 2003fff0
R 3 fffffff0 addi_neg16
P 00000000
P 00222020
R 4 00000007 add
P 00222822
R 5 ffffffef sub
P 00233024
R 6 fffffff0 and
P 00433825
R 7 fffffffc or
P 00404027
R 8 fffffff3 nor
P 0022482a
R 9 00000001 slt_neg
P 0043502a
R 10 00000000 slt_signed
P 200b0064
R 11 00000064 addi_base1
P 016b6020
R 12 000000c8 stall_dist1
P 200d0003
R 13 00000003 addi_base2
P 00000000
P 01ab7022
R 14 ffffff9f fwd_dist2
P 200fffff
R 15 ffffffff addi_base3
P 00000000
P 00000000
P 01ec8024
R 16 000000c8 wthru_dist3
P 00220020
P 20000037
P fc111234
P 20110009
R 17 00000009 reg0_reads_zero

/* tb.f */
rtl/cpu_pkg.sv
rtl/register_file.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/retire_stage.sv
rtl/pipeline_top.sv
verification/pipeline_checker.sv
verification/retire_monitor.sv
verification/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build the pipeline testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_top -f tb.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+1000 > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
if ! grep -q "Test passed" "$log"; then
    echo "no result line found in $log"
    exit 1
fi
exit 0

/* verification/tb_top.sv */
/*
 * pipeline testbench top
 * reads the program from the golden file, writes it through the load port
 * while reset is held, runs until every expected retirement is seen and
 * prints the closing report; a watchdog bounds the run
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top import cpu_pkg::*; ();
    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 10;
    localparam int          DRAIN_CYCLES = 8;     // window for stray retirements
    localparam int          MAX_IDLE     = 4;
    localparam int unsigned RAND_SEED    = 32'h588733e5;
    localparam string       GOLDEN_FILE  = "verification/golden_program.txt";

    logic       SYS_reset = 1'b0;
    logic       WB_exception_singal;
    logic       imem_we;
    imem_addr_t imem_addr;
    word_t      imem_data;
    logic       retire_valid;
    reg_addr_t  retire_reg;
    word_t      retire_data;
    logic       run_end;
    logic       end_done;
    logic       started;
    int         rec_count;
    int         seen;
    int         mismatches;
    int         other_errors;
    int         prog_len;
    int         load_errors;
    int         assert_fails;
    word_t      prog_mem [IMEM_DEPTH];

    always #(CLK_PERIOD / 2) SYS_reset = ~SYS_reset;

    pipeline_top pipeline_top_i (
        .SYS_reset           (SYS_reset),
        .WB_exception_singal (WB_exception_singal),
        .imem_we             (imem_we),
        .imem_addr           (imem_addr),
        .imem_data           (imem_data),
        .retire_valid        (retire_valid),
        .retire_reg          (retire_reg),
        .retire_data         (retire_data)
    );

    retire_monitor retire_monitor_i (
        .SYS_reset           (SYS_reset),
        .WB_exception_singal (WB_exception_singal),
        .retire_valid        (retire_valid),
        .retire_reg          (retire_reg),
        .retire_data         (retire_data),
        .run_end             (run_end),
        .rec_count           (rec_count),
        .seen                (seen),
        .mismatches          (mismatches),
        .other_errors        (other_errors),
        .end_done            (end_done)
    );

    assign assert_fails = pipeline_top_i.pipeline_checker_i.fail_count;

    // program words from the P lines
    task automatic read_program();
        int             fd;
        int             n;
        logic [8*80-1:0] line;
        logic [7:0]     tag;
        word_t          word;

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0)
        begin
            $display("Error: cannot open %s for the program words", GOLDEN_FILE);
            load_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = '0;
            tag  = '0;
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%s %h", tag, word);
            if (n == 2 && tag == "P")
            begin
                if (prog_len < IMEM_DEPTH)
                    prog_mem[prog_len] = word;
                else
                    load_errors++;          // program longer than the memory
                prog_len++;
            end
        end
        $fclose(fd);
        if (load_errors != 0)
            $display("Error: program has %0d words, memory holds %0d", prog_len, IMEM_DEPTH);
    endtask

    task automatic drive_word(input imem_addr_t addr, input word_t data);
        @(posedge SYS_reset);
        #1;
        imem_we   = 1'b1;
        imem_addr = addr;
        imem_data = data;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count)
        begin
            @(posedge SYS_reset);
            #1;
            imem_we = 1'b0;
        end
    endtask

    initial
    begin
        int          idle;
        word_t       word;

        WB_exception_singal = 1'b1;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_data   = '0;
        run_end     = 1'b0;
        started     = 1'b0;
        prog_len    = 0;
        load_errors = 0;
        void'($urandom(RAND_SEED));

        read_program();

        // words past the program get an unknown opcode
        for (int a = 0; a < IMEM_DEPTH; a++)
        begin
            idle = $urandom % MAX_IDLE;
            idle_cycles(idle);
            word = (a < prog_len) ? prog_mem[a] : {6'h3f, 20'd0, imem_addr_t'(a)};
            drive_word(imem_addr_t'(a), word);
        end
        idle_cycles(1);

        repeat (RESET_CYCLES) @(posedge SYS_reset);
        #1;
        WB_exception_singal = 1'b0;
        started = 1'b1;

        wait (seen >= rec_count);
        repeat (DRAIN_CYCLES) @(posedge SYS_reset);
        #1;
        run_end = 1'b1;                 // monitor closes its count check
        wait (end_done);
        @(posedge SYS_reset);
        #1;

        $display("retired %0d of %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 seen, rec_count, mismatches, other_errors + load_errors, assert_fails);
        if (mismatches + other_errors + load_errors + assert_fails == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // watchdog limit scales with program length and record count
    initial
    begin
        int limit;

        wait (started);
        limit = 4 * (prog_len + rec_count) + 20;
        repeat (limit) @(posedge SYS_reset);
        $display("Timeout: only %0d of %0d retirements seen %0d cycles after reset",
                 seen, rec_count, limit);
        $display("Test failed");
        $finish;
    end
endmodule

`default_nettype wire

/* verification/retire_monitor.sv */
/*
 * retire monitor
 * loads the expected retire records from the golden file and compares
 * every retirement against the next record, in program order
 */
`timescale 1ns/1ps
`default_nettype none

module retire_monitor import cpu_pkg::*; (
    input  logic      SYS_reset,
    input  logic      WB_exception_singal,
    input  logic      retire_valid,
    input  reg_addr_t retire_reg,
    input  word_t     retire_data,
    input  logic      run_end,
    output int        rec_count,
    output int        seen,
    output int        mismatches,
    output int        other_errors,
    output logic      end_done
);
    localparam string GOLDEN_FILE = "verification/golden_program.txt";

    reg_addr_t exp_reg [$];
    word_t     exp_data [$];
    string     exp_name [$];
    int        file_errors;
    int        order_errors;

    assign other_errors = file_errors + order_errors;

    initial
    begin
        int              fd;
        int              n;
        int              r;
        logic [8*80-1:0] line;
        logic [7:0]      tag;
        logic [8*16-1:0] name;
        word_t           value;

        rec_count   = 0;
        file_errors = 0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0)
        begin
            $display("Error: cannot open %s for the retire records", GOLDEN_FILE);
            file_errors = 1;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = '0;
                tag  = '0;
                name = '0;
                n    = $fgets(line, fd);
                n    = $sscanf(line, "%s %d %h %s", tag, r, value, name);
                if (n == 4 && tag == "R")
                begin
                    exp_reg.push_back(reg_addr_t'(r));
                    exp_data.push_back(value);
                    exp_name.push_back(string'(name));
                end
            end
            $fclose(fd);
            rec_count = exp_reg.size();
        end
    end

    // retire port is stable at the falling edge
    always @(negedge SYS_reset)
    begin
        if (WB_exception_singal)
        begin
            seen         = 0;
            mismatches   = 0;
            order_errors = 0;
            end_done     = 1'b0;
        end
        else
        begin
            if (retire_valid)
            begin
                if (seen < rec_count &&
                    (retire_reg !== exp_reg[seen] || retire_data !== exp_data[seen]))
                begin
                    $display("Mismatch in %s: expected r%0d = %h, actual r%0d = %h",
                             exp_name[seen], exp_reg[seen], exp_data[seen],
                             retire_reg, retire_data);
                    mismatches++;
                end
                seen++;
            end
            if (run_end && !end_done)
            begin
                if (seen < rec_count)
                begin
                    $display("Error: %0d expected retirements never appeared", rec_count - seen);
                    order_errors++;
                end
                else if (seen > rec_count)
                begin
                    $display("Error: %0d retirements beyond the %0d expected",
                             seen - rec_count, rec_count);
                    order_errors++;
                end
                end_done = 1'b1;
            end
        end
    end
endmodule

`default_nettype wire

/* verification/pipeline_checker.sv */
/*
 * pipeline checker
 * concurrent assertions on the retire port, bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

module pipeline_checker import cpu_pkg::*; (
    input logic      SYS_reset,
    input logic      WB_exception_singal,
    input logic      retire_valid,
    input reg_addr_t retire_reg,
    input word_t     retire_data
);
    int reset_fails = 0;
    int reg_fails   = 0;
    int data_fails  = 0;
    int fail_count;

    assign fail_count = reset_fails + reg_fails + data_fails;

    quiet_in_reset: assert property (@(posedge SYS_reset)
        WB_exception_singal |-> !retire_valid)
    else
    begin
        reset_fails++;
        $error("retire_valid high while reset is asserted");
    end

    // register 0 writes are dropped in decode
    reg_nonzero: assert property (@(posedge SYS_reset) disable iff (WB_exception_singal)
        retire_valid |-> retire_reg != '0)
    else
    begin
        reg_fails++;
        $error("retirement reported for register 0");
    end

    data_known: assert property (@(posedge SYS_reset) disable iff (WB_exception_singal)
        retire_valid |-> !$isunknown(retire_data))
    else
    begin
        data_fails++;
        $error("retire_data unknown on a retirement");
    end
endmodule

bind pipeline_top pipeline_checker pipeline_checker_i (
    .SYS_reset           (SYS_reset),
    .WB_exception_singal (WB_exception_singal),
    .retire_valid        (retire_valid),
    .retire_reg          (retire_reg),
    .retire_data         (retire_data)
);

`default_nettype wire

/* rtl/pipeline_top.sv */
/*
 * pipeline top
 * five-stage in-order integer pipeline: fetch, decode, execute,
 * memory pass-through and write-back, with instruction load and retire ports
 */
`timescale 1ns/1ps
`default_nettype none

module pipeline_top import cpu_pkg::*; (
    input  logic       SYS_reset,
    input  logic       WB_exception_singal,
    input  logic       imem_we,
    input  imem_addr_t imem_addr,
    input  word_t      imem_data,
    output logic       retire_valid,
    output reg_addr_t  retire_reg,
    output word_t      retire_data
);
    word_t     d_instr;
    logic      stall;
    logic      fwd_rs;
    logic      fwd_rt;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      uses_rt;
    word_t     op_a;
    word_t     op_b;
    word_t     imm;
    logic      use_imm;
    alu_op_e   alu_op;
    reg_addr_t dest;
    logic      reg_write;
    reg_addr_t ex_dest;
    logic      ex_write;
    word_t     ex_result;
    reg_addr_t mem_dest;
    logic      mem_write;
    word_t     mem_result;

    fetch_unit fetch_unit_i (
        .SYS_reset (SYS_reset), .WB_exception_singal (WB_exception_singal),
        .imem_we (imem_we), .imem_addr (imem_addr), .imem_data (imem_data),
        .stall (stall), .d_instr (d_instr),
        .d_pc ()                                    // pc trace only
    );

    decode_stage decode_stage_i (
        .SYS_reset (SYS_reset), .WB_exception_singal (WB_exception_singal),
        .d_instr (d_instr),
        .wb_we (retire_valid), .wb_reg (retire_reg), .wb_data (retire_data),
        .fwd_rs (fwd_rs), .fwd_rt (fwd_rt), .mem_result (mem_result),
        .rs (rs), .rt (rt), .uses_rt (uses_rt), .op_a (op_a), .op_b (op_b),
        .imm (imm), .use_imm (use_imm), .alu_op (alu_op), .dest (dest),
        .reg_write (reg_write)
    );

    hazard_unit hazard_unit_i (
        .rs (rs), .rt (rt), .uses_rt (uses_rt),
        .ex_dest (ex_dest), .ex_write (ex_write),
        .mem_dest (mem_dest), .mem_write (mem_write),
        .stall (stall), .fwd_rs (fwd_rs), .fwd_rt (fwd_rt)
    );

    execute_stage execute_stage_i (
        .SYS_reset (SYS_reset), .WB_exception_singal (WB_exception_singal),
        .stall (stall), .op_a (op_a), .op_b (op_b), .imm (imm),
        .use_imm (use_imm), .alu_op (alu_op), .dest (dest), .reg_write (reg_write),
        .ex_dest (ex_dest), .ex_write (ex_write), .ex_result (ex_result)
    );

    retire_stage retire_stage_i (
        .SYS_reset (SYS_reset), .WB_exception_singal (WB_exception_singal),
        .ex_dest (ex_dest), .ex_write (ex_write), .ex_result (ex_result),
        .mem_dest (mem_dest), .mem_write (mem_write), .mem_result (mem_result),
        .retire_valid (retire_valid), .retire_reg (retire_reg),
        .retire_data (retire_data)
    );
endmodule

`default_nettype wire

/* rtl/retire_stage.sv */
/*
 * retire stage
 * memory-stage register (pass-through, feeds forwarding) followed by
 * the write-back register that drives the register file and retire port
 */
`timescale 1ns/1ps
`default_nettype none

module retire_stage import cpu_pkg::*; (
    input  logic      SYS_reset,
    input  logic      WB_exception_singal,
    input  reg_addr_t ex_dest,
    input  logic      ex_write,
    input  word_t     ex_result,
    output reg_addr_t mem_dest,
    output logic      mem_write,
    output word_t     mem_result,
    output logic      retire_valid,
    output reg_addr_t retire_reg,
    output word_t     retire_data
);
    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
        begin
            mem_write    <= 1'b0;
            mem_dest     <= '0;
            retire_valid <= 1'b0;
            retire_reg   <= '0;
        end
        else
        begin
            mem_write    <= ex_write;
            mem_dest     <= ex_dest;
            retire_valid <= mem_write;  // doubles as register file write enable
            retire_reg   <= mem_dest;
        end
    end

    always_ff @(posedge SYS_reset)
    begin
        mem_result  <= ex_result;
        retire_data <= mem_result;
    end
endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
/*
 * execute stage
 * decode-to-execute register, loading a bubble on stall, and the ALU
 * (add, sub, and, or, signed slt, nor; overflow ignored)
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic      SYS_reset,
    input  logic      WB_exception_singal,
    input  logic      stall,
    input  word_t     op_a,
    input  word_t     op_b,
    input  word_t     imm,
    input  logic      use_imm,
    input  alu_op_e   alu_op,
    input  reg_addr_t dest,
    input  logic      reg_write,
    output reg_addr_t ex_dest,
    output logic      ex_write,
    output word_t     ex_result
);
    word_t   ex_a;
    word_t   ex_b;
    alu_op_e ex_op;

    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
        begin
            ex_write <= 1'b0;
            ex_dest  <= '0;
        end
        else if (stall)
        begin
            ex_write <= 1'b0;       // bubble
            ex_dest  <= '0;
        end
        else
        begin
            ex_write <= reg_write;
            ex_dest  <= dest;
        end
    end

    always_ff @(posedge SYS_reset)
    begin
        ex_a  <= op_a;
        ex_b  <= use_imm ? imm : op_b;  // operand b chosen before the register
        ex_op <= alu_op;
    end

    always_comb
    begin
        case (ex_op)
            ALU_ADD: ex_result = ex_a + ex_b;
            ALU_SUB: ex_result = ex_a - ex_b;
            ALU_AND: ex_result = ex_a & ex_b;
            ALU_OR:  ex_result = ex_a | ex_b;
            ALU_SLT: ex_result = {31'd0, $signed(ex_a) < $signed(ex_b)};
            ALU_NOR: ex_result = ~(ex_a | ex_b);
            default: ex_result = '0;
        endcase
    end
endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
/*
 * hazard unit
 * compares decode sources with the execute and memory-stage destinations:
 * a match in execute stalls decode one cycle, a match in memory forwards
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      uses_rt,
    input  reg_addr_t ex_dest,
    input  logic      ex_write,
    input  reg_addr_t mem_dest,
    input  logic      mem_write,
    output logic      stall,
    output logic      fwd_rs,
    output logic      fwd_rt
);
    logic ex_hit_rs;
    logic ex_hit_rt;

    assign ex_hit_rs = (rs == ex_dest);
    assign ex_hit_rt = uses_rt && (rt == ex_dest);

    // result still in the ALU so decode waits for the memory stage
    assign stall = ex_write && (ex_hit_rs || ex_hit_rt);

    // dest is never 0 when a write flag is set, so rs of 0 never matches
    assign fwd_rs = mem_write && (rs == mem_dest);
    assign fwd_rt = mem_write && uses_rt && (rt == mem_dest);
endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
/*
 * decode stage
 * splits the instruction in the decode register into fields, decodes
 * control, sign-extends the immediate and picks forwarded operands
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  logic      SYS_reset,
    input  logic      WB_exception_singal,
    input  word_t     d_instr,
    input  logic      wb_we,
    input  reg_addr_t wb_reg,
    input  word_t     wb_data,
    input  logic      fwd_rs,
    input  logic      fwd_rt,
    input  word_t     mem_result,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output logic      uses_rt,
    output word_t     op_a,
    output word_t     op_b,
    output word_t     imm,
    output logic      use_imm,
    output alu_op_e   alu_op,
    output reg_addr_t dest,
    output logic      reg_write
);
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs_field;
    reg_addr_t rd_field;
    logic      instr_valid;
    logic      dest_is_rd;
    word_t     data_a;
    word_t     data_b;

    assign opcode   = d_instr[31:26];
    assign rs_field = d_instr[25:21];
    assign rt       = d_instr[20:16];
    assign rd_field = d_instr[15:11];
    assign funct    = d_instr[5:0];

    always_comb
    begin
        instr_valid = 1'b0;
        dest_is_rd  = 1'b0;
        use_imm     = 1'b0;
        alu_op      = ALU_ADD;
        case (opcode)
            OPC_RTYPE:
            begin
                instr_valid = 1'b1;
                dest_is_rd  = 1'b1;
                case (funct)
                    FUNCT_ADD: alu_op = ALU_ADD;
                    FUNCT_SUB: alu_op = ALU_SUB;
                    FUNCT_AND: alu_op = ALU_AND;
                    FUNCT_OR:  alu_op = ALU_OR;
                    FUNCT_SLT: alu_op = ALU_SLT;
                    FUNCT_NOR: alu_op = ALU_NOR;
                    default:   instr_valid = 1'b0;  // includes the all-zero nop
                endcase
            end
            OPC_ADDI:
            begin
                instr_valid = 1'b1;
                use_imm     = 1'b1;
            end
            default: instr_valid = 1'b0;            // unknown opcode runs as nop
        endcase
    end

    assign rs        = instr_valid ? rs_field : '0;  // no false stall on a nop
    assign uses_rt   = instr_valid && !use_imm;
    assign dest      = dest_is_rd ? rd_field : rt;
    assign reg_write = instr_valid && (dest != '0);  // register 0 writes dropped here
    assign imm       = {{16{d_instr[15]}}, d_instr[15:0]};

    register_file register_file_i (
        .SYS_reset           (SYS_reset),
        .WB_exception_singal (WB_exception_singal),
        .rd_a                (rs_field),
        .rd_b                (rt),
        .data_a              (data_a),
        .data_b              (data_b),
        .we                  (wb_we),
        .wr_reg              (wb_reg),
        .wr_data             (wb_data)
    );

    assign op_a = fwd_rs ? mem_result : data_a;   // memory-stage result wins
    assign op_b = fwd_rt ? mem_result : data_b;
endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
/*
 * fetch unit
 * program counter, instruction memory with a synchronous load port,
 * and the fetch-to-decode register; pc and register hold on stall
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import cpu_pkg::*; (
    input  logic       SYS_reset,
    input  logic       WB_exception_singal,
    input  logic       imem_we,
    input  imem_addr_t imem_addr,
    input  word_t      imem_data,
    input  logic       stall,
    output word_t      d_instr,
    output word_t      d_pc
);
    word_t      pc;
    imem_addr_t fetch_idx;
    word_t      imem [IMEM_DEPTH];

    assign fetch_idx = imem_addr_t'((pc - RESET_PC) >> 2);   // word index from reset vector

    // load port stays live while reset is held
    always_ff @(posedge SYS_reset)
    begin
        if (imem_we)
            imem[imem_addr] <= imem_data;
    end

    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
        begin
            pc      <= RESET_PC;
            d_instr <= '0;              // nop in decode
            d_pc    <= RESET_PC;
        end
        else if (!stall)
        begin
            pc      <= pc + 32'd4;
            d_instr <= imem[fetch_idx];
            d_pc    <= pc;
        end
    end
endmodule

`default_nettype wire

/* rtl/register_file.sv */
/*
 * register file
 * 32 x 32-bit, two combinational read ports and one write port;
 * a read of the register being written returns the new value
 */
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic      SYS_reset,
    input  logic      WB_exception_singal,
    input  reg_addr_t rd_a,
    input  reg_addr_t rd_b,
    output word_t     data_a,
    output word_t     data_b,
    input  logic      we,
    input  reg_addr_t wr_reg,
    input  word_t     wr_data
);
    word_t regs [2**$bits(reg_addr_t)];

    // register 0 is cleared here and never written, so it reads zero
    always_ff @(posedge SYS_reset or posedge WB_exception_singal)
    begin
        if (WB_exception_singal)
        begin
            for (int i = 0; i < 2**$bits(reg_addr_t); i++)
                regs[i] <= '0;
        end
        else if (we)
            regs[wr_reg] <= wr_data;
    end

    assign data_a = (we && wr_reg == rd_a) ? wr_data : regs[rd_a];  // write-through
    assign data_b = (we && wr_reg == rd_b) ? wr_data : regs[rd_b];
endmodule

`default_nettype wire

/* rtl/cpu_pkg.sv */
/*
 * cpu package
 * word and field types, opcode and funct codes, ALU operation enum,
 * reset vector and instruction memory depth for the five-stage pipeline
 */
`default_nettype none

package cpu_pkg;
    typedef logic [31:0] word_t;        // data, instruction and pc
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [5:0]  imem_addr_t;   // instruction memory word index

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_NOR} alu_op_e;

    localparam opcode_t OPC_RTYPE = 6'd0;
    localparam opcode_t OPC_ADDI  = 6'd8;

    localparam funct_t FUNCT_ADD = 6'd32;
    localparam funct_t FUNCT_SUB = 6'd34;
    localparam funct_t FUNCT_AND = 6'd36;
    localparam funct_t FUNCT_OR  = 6'd37;
    localparam funct_t FUNCT_NOR = 6'd39;
    localparam funct_t FUNCT_SLT = 6'd42;

    localparam word_t RESET_PC   = 32'h0040_0000;
    localparam int    IMEM_DEPTH = 64;
endpackage

`default_nettype wire
